//--- logic/syscfg_defs.svh
`ifndef SYSCFG_DEFS_SVH
`define SYSCFG_DEFS_SVH

// APB data and address widths
`define SYSCFG_DATA_W 32
`define SYSCFG_ADDR_W 12

// One strobe per data byte
`define SYSCFG_STRB_W (`SYSCFG_DATA_W / 8)

// Number of incoming interrupt lines, one per IER bit
`define SYSCFG_IRQ_W `SYSCFG_DATA_W

// Cycles the target stays in reset during a reset action
`define SYSCFG_RST_HOLD 16

`endif

//--- logic/syscfg_pkg.sv
`default_nettype none

`include "syscfg_defs.svh"

package syscfg_pkg;

    // Action codes written to MR, unlisted codes behave as IDLE
    typedef enum logic [3:0] {
        IDLE   = 4'd0,
        RESUME = 4'd1,
        PAUSE  = 4'd2,
        STOP   = 4'd3,
        RESET  = 4'd4
    } action_t;

    // Maestro sequencer states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RESUME,
        ST_PAUSE,
        ST_STOP,
        ST_RESET,
        ST_HOLD
    } maestro_state_t;

    // Register word index taken from paddr above the byte offset
    typedef enum logic [`SYSCFG_ADDR_W-$clog2(`SYSCFG_STRB_W)-1:0] {
        SR  = 'd0,
        MR  = 'd1,
        BAR = 'd2,
        IER = 'd3
    } reg_index_t;

endpackage

`default_nettype wire

//--- logic/syscfg_ctl_if.sv
`default_nettype none

interface syscfg_ctl_if import syscfg_pkg::*; ();

    // Pending action from MR, back to IDLE once the APB write completes
    action_t action;

    // Maestro is sequencing an action
    logic busy;

    // Target status as seen by software in SR
    logic paused;
    logic stopped;

    modport regs (
        output action,
        input  busy,
        input  paused,
        input  stopped
    );

    modport maestro (
        input  action,
        output busy,
        output paused,
        output stopped
    );

endinterface

`default_nettype wire

//--- logic/rst_hold_timer.sv
`default_nettype none

`include "syscfg_defs.svh"

module rst_hold_timer (
    input  wire logic seq,
    input  wire logic rst,
    input  wire logic start,
    output logic      done
);

    localparam int unsigned CNT_W = $clog2(`SYSCFG_RST_HOLD + 1);

    logic [CNT_W-1:0] count;

    // Load on start, then count down to zero and stay there
    always_ff @(posedge seq) begin
        if (rst) begin
            count <= '0;
        end else if (start) begin
            count <= CNT_W'(`SYSCFG_RST_HOLD);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // Low already in the start cycle
    assign done = (count == '0) && !start;

endmodule

`default_nettype wire

//--- logic/syscfg_regs.sv
`default_nettype none

`include "syscfg_defs.svh"

module syscfg_regs import syscfg_pkg::*; (
    input  wire logic                        seq,
    input  wire logic                        rst,

    input  wire logic                        psel,
    input  wire logic                        penable,
    input  wire logic                        pwrite,
    input  wire logic [`SYSCFG_ADDR_W-1:0]   paddr,
    input  wire logic [`SYSCFG_DATA_W-1:0]   pwdata,
    input  wire logic [`SYSCFG_STRB_W-1:0]   pstrb,
    output logic                             pready,
    output logic      [`SYSCFG_DATA_W-1:0]   prdata,
    output logic                             pslverr,

    input  wire logic [`SYSCFG_IRQ_W-1:0]    irq_vec,
    output logic      [`SYSCFG_DATA_W-1:0]   boot_addr,
    output logic                             irq,

    syscfg_ctl_if.regs                       ctl
);

    localparam int unsigned DATA_W = `SYSCFG_DATA_W;
    localparam int unsigned OFFS_W = $clog2(`SYSCFG_STRB_W);

    logic [DATA_W-1:0] bar_r;
    logic [DATA_W-1:0] ier_r;

    logic [DATA_W-1:0] mask;
    logic [DATA_W-1:0] sr_word;
    logic [DATA_W-1:0] mr_word;
    reg_index_t        index;
    logic              mr_locked;

    // Word index, byte offset bits are ignored
    assign index = reg_index_t'(paddr[`SYSCFG_ADDR_W-1:OFFS_W]);

    // Expand byte strobes to a bit mask
    always_comb begin
        for (int i = 0; i < `SYSCFG_STRB_W; i++) begin
            mask[i*8 +: 8] = pstrb[i] ? 8'hff : 8'h00;
        end
    end

    assign sr_word = {{(DATA_W-2){1'b0}}, ctl.stopped, ctl.paused};
    assign mr_word = {{(DATA_W-4){1'b0}}, ctl.action};

    // MR and BAR only change while the maestro is quiet
    assign mr_locked = ctl.busy || (ctl.action != IDLE);

    always_ff @(posedge seq) begin
        if (rst) begin
            ctl.action <= IDLE;
            bar_r      <= '0;
            ier_r      <= '0;
            pready     <= 1'b0;
            pslverr    <= 1'b0;
        end else if (psel && !pready) begin
            // Response is registered, one cycle after setup
            pready <= 1'b1;
            prdata <= '0;
            case (index)
                SR: begin
                    if (pwrite) begin
                        pslverr <= 1'b1;
                    end else begin
                        prdata <= sr_word;
                    end
                end
                MR: begin
                    if (!pwrite) begin
                        prdata <= mr_word;
                    end else if (mr_locked) begin
                        pslverr <= 1'b1;
                    end else begin
                        ctl.action <= action_t'(pwdata[3:0] & mask[3:0]);
                    end
                end
                BAR: begin
                    if (!pwrite) begin
                        prdata <= bar_r;
                    end else if (mr_locked) begin
                        pslverr <= 1'b1;
                    end else begin
                        bar_r <= (pwdata & mask) | (bar_r & ~mask);
                    end
                end
                IER: begin
                    if (pwrite) begin
                        ier_r <= (pwdata & mask) | (ier_r & ~mask);
                    end else begin
                        prdata <= ier_r;
                    end
                end
                default: begin
                    // Unmapped word
                    pslverr <= 1'b1;
                end
            endcase
        end else if (psel && penable && pready) begin
            // Access phase done, action was a one-transfer request
            pready     <= 1'b0;
            pslverr    <= 1'b0;
            ctl.action <= IDLE;
        end
    end

    assign boot_addr = bar_r;

    // Single interrupt toward the target
    assign irq = |(ier_r[`SYSCFG_IRQ_W-1:0] & irq_vec);

    a_pready_needs_psel : assert property (
        @(posedge seq) disable iff (rst)
        $rose(pready) |-> $past(psel)
    ) else $error("pready rose without psel");

    a_pslverr_with_pready : assert property (
        @(posedge seq) disable iff (rst)
        pslverr |-> pready
    ) else $error("pslverr high while pready low");

endmodule

`default_nettype wire

//--- logic/syscfg_maestro.sv
`default_nettype none

module syscfg_maestro import syscfg_pkg::*; (
    input  wire logic    seq,
    input  wire logic    rst,

    input  wire logic    tgt_pause_ack,
    output logic         tgt_rst,
    output logic         tgt_pause_req,

    output logic         hold_start,
    input  wire logic    hold_done,

    syscfg_ctl_if.maestro ctl
);

    maestro_state_t state;
    logic           paused;
    logic           stopped;
    logic           pause_done;
    logic           resume_done;

    // Level handshake with the target
    assign pause_done  = tgt_pause_req && tgt_pause_ack;
    assign resume_done = !tgt_pause_req && !tgt_pause_ack;

    always_ff @(posedge seq) begin
        if (rst) begin
            // Target comes up held in reset and paused
            state         <= ST_IDLE;
            tgt_rst       <= 1'b1;
            tgt_pause_req <= 1'b1;
            hold_start    <= 1'b0;
            paused        <= 1'b0;
            stopped       <= 1'b0;
        end else begin
            hold_start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    case (ctl.action)
                        RESUME:  state <= ST_RESUME;
                        PAUSE:   state <= ST_PAUSE;
                        STOP:    state <= ST_STOP;
                        RESET:   state <= ST_RESET;
                        default: state <= ST_IDLE;
                    endcase
                end
                ST_PAUSE: begin
                    tgt_pause_req <= 1'b1;
                    if (pause_done) begin
                        paused <= 1'b1;
                        state  <= ST_IDLE;
                    end
                end
                ST_STOP: begin
                    tgt_pause_req <= 1'b1;
                    if (pause_done) begin
                        tgt_rst <= 1'b1;
                        stopped <= 1'b1;
                        state   <= ST_IDLE;
                    end
                end
                ST_RESET: begin
                    tgt_pause_req <= 1'b1;
                    if (pause_done) begin
                        tgt_rst    <= 1'b1;
                        stopped    <= 1'b1;
                        hold_start <= 1'b1;
                        state      <= ST_HOLD;
                    end
                end
                ST_HOLD: begin
                    // Keep reset asserted until the timer runs out
                    if (hold_done) begin
                        state <= ST_RESUME;
                    end
                end
                ST_RESUME: begin
                    tgt_rst       <= 1'b0;
                    tgt_pause_req <= 1'b0;
                    if (resume_done) begin
                        paused  <= 1'b0;
                        stopped <= 1'b0;
                        state   <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    assign ctl.busy    = (state != ST_IDLE);
    assign ctl.paused  = paused;
    assign ctl.stopped = stopped;

    // Reset is only released together with the resume request
    a_rst_release : assert property (
        @(posedge seq) disable iff (rst)
        ($fell(tgt_rst) && $past(tgt_pause_req)) |-> $past(state == ST_RESUME)
    ) else $error("tgt_rst released outside ST_RESUME");

    // Timer sees a single start and leaves done low the next cycle
    a_hold_start_pulse : assert property (
        @(posedge seq) disable iff (rst)
        hold_start |=> (!hold_start && !hold_done)
    ) else $error("hold_start is not a one-cycle pulse");

endmodule

`default_nettype wire

//--- logic/syscfg_tgt.sv
`default_nettype none

`include "syscfg_defs.svh"

module syscfg_tgt (
    input  wire logic                        seq,
    input  wire logic                        rst,

    input  wire logic                        psel,
    input  wire logic                        penable,
    input  wire logic                        pwrite,
    input  wire logic [`SYSCFG_ADDR_W-1:0]   paddr,
    input  wire logic [`SYSCFG_DATA_W-1:0]   pwdata,
    input  wire logic [`SYSCFG_STRB_W-1:0]   pstrb,
    output logic                             pready,
    output logic      [`SYSCFG_DATA_W-1:0]   prdata,
    output logic                             pslverr,

    input  wire logic [`SYSCFG_IRQ_W-1:0]    irq_vec,
    input  wire logic                        tgt_pause_ack,

    output logic                             tgt_rst,
    output logic                             tgt_pause_req,
    output logic      [`SYSCFG_DATA_W-1:0]   tgt_boot_addr,
    output logic                             tgt_irq
);

    logic hold_start;
    logic hold_done;

    syscfg_ctl_if ctl ();

    syscfg_regs i_regs (
        .seq       (seq),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .pstrb     (pstrb),
        .pready    (pready),
        .prdata    (prdata),
        .pslverr   (pslverr),
        .irq_vec   (irq_vec),
        .boot_addr (tgt_boot_addr),
        .irq       (tgt_irq),
        .ctl       (ctl.regs)
    );

    syscfg_maestro i_maestro (
        .seq           (seq),
        .rst           (rst),
        .tgt_pause_ack (tgt_pause_ack),
        .tgt_rst       (tgt_rst),
        .tgt_pause_req (tgt_pause_req),
        .hold_start    (hold_start),
        .hold_done     (hold_done),
        .ctl           (ctl.maestro)
    );

    rst_hold_timer i_hold_timer (
        .seq   (seq),
        .rst   (rst),
        .start (hold_start),
        .done  (hold_done)
    );

endmodule

`default_nettype wire

//--- verif/tb_clock.sv
`default_nettype none

module tb_clock #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 8
) (
    output logic seq,
    output logic rst
);

    initial begin
        seq = 1'b0;
        forever #(PERIOD / 2) seq = ~seq;
    end

    // Reset released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(negedge seq);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- verif/syscfg_tb.sv
`default_nettype none

`include "syscfg_defs.svh"

module syscfg_tb import syscfg_pkg::*; ();

    localparam int PERIOD    = 100;
    localparam int NUM_STEPS = 9;

    localparam logic [11:0] ADDR_SR  = 12'h000;
    localparam logic [11:0] ADDR_MR  = 12'h004;
    localparam logic [11:0] ADDR_BAR = 12'h008;
    localparam logic [11:0] ADDR_IER = 12'h00c;

    logic        seq;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [3:0]  pstrb;
    logic        pready;
    logic [31:0] prdata;
    logic        pslverr;
    logic [31:0] irq_vec;
    logic        tgt_pause_ack;
    logic        tgt_rst;
    logic        tgt_pause_req;
    logic [31:0] tgt_boot_addr;
    logic        tgt_irq;

    // Shadow state of the reference model
    logic [31:0] bar_shadow = '0;
    logic [31:0] ier_shadow = '0;
    logic [1:0]  status_shadow = '0;

    logic [31:0] lfsr = 32'h5e22_1075;
    logic        xfer_busy = 1'b0;
    int          errors = 0;
    int          ack_wait = 0;
    logic [32:0] exp_q[$];
    logic [32:0] act_q[$];

    tb_clock #(.PERIOD(PERIOD), .RST_CYCLES(8)) i_tb_clock (.seq(seq), .rst(rst));

    syscfg_tgt i_syscfg_tgt (
        .seq(seq), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .pstrb(pstrb), .pready(pready), .prdata(prdata),
        .pslverr(pslverr), .irq_vec(irq_vec), .tgt_pause_ack(tgt_pause_ack),
        .tgt_rst(tgt_rst), .tgt_pause_req(tgt_pause_req),
        .tgt_boot_addr(tgt_boot_addr), .tgt_irq(tgt_irq)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hd000_0001;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    function automatic logic irq_expect(input logic [31:0] ier, input logic [31:0] vec);
        return |(ier & vec);
    endfunction

    // Expected {pslverr, prdata} of one transfer, updates the shadows on accepted writes
    function automatic logic [32:0] syscfg_expect(input logic wr, input logic [11:0] addr,
            input logic [31:0] wdata, input logic [3:0] strb, input logic locked);
        logic [9:0]  idx;
        logic [31:0] mask;
        logic [31:0] rdata;
        logic        err;
        idx   = addr[11:2];
        rdata = '0;
        err   = 1'b0;
        for (int i = 0; i < 4; i++) begin
            mask[i*8 +: 8] = {8{strb[i]}};
        end
        if (idx > 10'd3) begin
            err = 1'b1;
        end else if (idx == 10'd0) begin
            if (wr) err = 1'b1;
            else rdata = {30'b0, status_shadow};
        end else if (idx == 10'd1) begin
            // Action returns to IDLE on completion, so reads show zero
            if (wr && locked) err = 1'b1;
        end else if (idx == 10'd2) begin
            if (!wr) rdata = bar_shadow;
            else if (locked) err = 1'b1;
            else bar_shadow = (wdata & mask) | (bar_shadow & ~mask);
        end else begin
            if (!wr) rdata = ier_shadow;
            else ier_shadow = (wdata & mask) | (ier_shadow & ~mask);
        end
        return {err, rdata};
    endfunction

    task automatic report_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        errors++;
        $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
    endtask

    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            input logic [3:0] strb, input logic locked, input logic chk,
                            output logic [31:0] rdata, output logic err);
        int waits;
        @(negedge seq);
        xfer_busy = 1'b1;
        psel      = 1'b1;
        penable   = 1'b0;
        pwrite    = wr;
        paddr     = addr;
        pwdata    = wdata;
        pstrb     = strb;
        @(negedge seq);
        penable = 1'b1;
        waits   = 0;
        while (!pready && waits < 16) begin
            @(negedge seq);
            waits++;
        end
        if (!pready) begin
            errors++;
            $display("APB transfer to address %h got no pready", addr);
        end
        // Completion happens on the next rising edge
        rdata = prdata;
        err   = pslverr;
        if (chk) begin
            exp_q.push_back(syscfg_expect(wr, addr, wdata, strb, locked));
            act_q.push_back({err, rdata});
        end
        @(negedge seq);
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        xfer_busy = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic locked);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b1, addr, data, strb, locked, 1'b1, rdata, err);
    endtask

    task automatic apb_read(input logic [11:0] addr);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b0, addr, '0, 4'h0, 1'b0, 1'b1, rdata, err);
    endtask

    // Poll SR until it shows the shadow status, then read it once more as a check
    task automatic wait_status();
        logic [31:0] rdata;
        logic        err;
        int          tries;
        tries = 0;
        rdata = 32'hffff_ffff;
        while (rdata != {30'b0, status_shadow} && tries < 100) begin
            apb_xfer(1'b0, ADDR_SR, '0, 4'h0, 1'b0, 1'b0, rdata, err);
            tries++;
        end
        if (rdata != {30'b0, status_shadow}) begin
            errors++;
            $display("SR never reached status %b", status_shadow);
        end
        apb_read(ADDR_SR);
    endtask

    // Target model, ack follows req after a random delay
    always @(negedge seq) begin
        if (rst) begin
            tgt_pause_ack = 1'b0;
            ack_wait      = 0;
        end else if (tgt_pause_req != tgt_pause_ack) begin
            if (ack_wait == 0) begin
                ack_wait = 1 + int'(take_bits(3));
            end else if (ack_wait == 1) begin
                tgt_pause_ack = tgt_pause_req;
                ack_wait      = 0;
            end else begin
                ack_wait--;
            end
        end else begin
            ack_wait = 0;
        end
    end

    // Compare completed transfers
    always @(negedge seq) begin : compare_xfers
        logic [32:0] e;
        logic [32:0] a;
        while (exp_q.size() > 0 && act_q.size() > 0) begin
            e = exp_q.pop_front();
            a = act_q.pop_front();
            if (a[32] !== e[32]) report_value("pslverr", 32'(e[32]), 32'(a[32]));
            if (a[31:0] !== e[31:0]) report_value("prdata", e[31:0], a[31:0]);
        end
    end

    // Outputs that only move during a transfer are sampled between transfers
    always @(posedge seq) begin
        if (!rst && !xfer_busy) begin
            if (tgt_boot_addr !== bar_shadow) begin
                report_value("tgt_boot_addr", bar_shadow, tgt_boot_addr);
            end
            if (tgt_irq !== irq_expect(ier_shadow, irq_vec)) begin
                report_value("tgt_irq", 32'(irq_expect(ier_shadow, irq_vec)), 32'(tgt_irq));
            end
        end
    end

    initial begin
        #(200 * NUM_STEPS * PERIOD);
        $display("Timeout: the test did not finish in %0d cycles", 200 * NUM_STEPS);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int          waits;
        int          hold;
        logic [31:0] ier_word;
        logic        rst_before;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        pstrb         = '0;
        irq_vec       = '0;
        tgt_pause_ack = 1'b0;
        wait (!rst);
        @(negedge seq);

        // Values right after reset
        if (tgt_rst !== 1'b1) report_value("tgt_rst", 32'd1, 32'(tgt_rst));
        if (tgt_pause_req !== 1'b1) report_value("tgt_pause_req", 32'd1, 32'(tgt_pause_req));
        if (pready !== 1'b0) report_value("pready", 32'd0, 32'(pready));
        if (pslverr !== 1'b0) report_value("pslverr", 32'd0, 32'(pslverr));
        if (tgt_irq !== 1'b0) report_value("tgt_irq", 32'd0, 32'(tgt_irq));
        apb_read(ADDR_SR);

        // Byte-strobe merges on BAR and IER
        apb_write(ADDR_BAR, 32'h1234_5678, 4'hf, 1'b0);
        apb_write(ADDR_BAR, 32'haabb_ccdd, 4'b0101, 1'b0);
        apb_read(ADDR_BAR);
        apb_write(ADDR_BAR, take_bits(32), 4'(take_bits(4)), 1'b0);
        apb_read(ADDR_BAR);
        apb_write(ADDR_IER, 32'hffff_0000, 4'b1010, 1'b0);
        apb_write(ADDR_IER, take_bits(32), 4'(take_bits(4)), 1'b0);
        apb_read(ADDR_IER);

        // Error responses
        apb_write(ADDR_SR, 32'h0000_0003, 4'hf, 1'b0);
        apb_read(12'h010);
        apb_write(12'h3fc, 32'hffff_ffff, 4'hf, 1'b0);

        // Release the target from its reset state
        apb_write(ADDR_MR, 32'(RESUME), 4'hf, 1'b0);
        waits = 0;
        while ((tgt_pause_req || tgt_pause_ack) && waits < 100) begin
            @(negedge seq);
            waits++;
        end
        if (tgt_pause_req || tgt_pause_ack) begin
            errors++;
            $display("Target pause pair never dropped after RESUME");
        end
        @(negedge seq);
        apb_read(ADDR_SR);
        if (tgt_rst !== 1'b0) report_value("tgt_rst", 32'd0, 32'(tgt_rst));

        // PAUSE with a BAR write refused while it runs
        rst_before = tgt_rst;
        apb_write(ADDR_MR, 32'(PAUSE), 4'hf, 1'b0);
        apb_write(ADDR_BAR, 32'hdead_beef, 4'hf, 1'b1);
        if (tgt_pause_req !== 1'b1) report_value("tgt_pause_req", 32'd1, 32'(tgt_pause_req));
        status_shadow = 2'b01;
        wait_status();
        if (tgt_rst !== rst_before) report_value("tgt_rst", 32'(rst_before), 32'(tgt_rst));
        apb_read(ADDR_BAR);

        // STOP keeps paused and adds stopped
        apb_write(ADDR_MR, 32'(STOP), 4'hf, 1'b0);
        status_shadow = 2'b11;
        wait_status();
        if (tgt_rst !== 1'b1) report_value("tgt_rst", 32'd1, 32'(tgt_rst));

        // RESUME with an MR write refused while it runs
        apb_write(ADDR_MR, 32'(RESUME), 4'hf, 1'b0);
        apb_write(ADDR_MR, 32'(PAUSE), 4'hf, 1'b1);
        status_shadow = 2'b00;
        wait_status();
        if (tgt_rst !== 1'b0) report_value("tgt_rst", 32'd0, 32'(tgt_rst));
        if (tgt_pause_req !== 1'b0) report_value("tgt_pause_req", 32'd0, 32'(tgt_pause_req));

        // RESET from the running state, hold length counted from the rise
        apb_write(ADDR_MR, 32'(RESET), 4'hf, 1'b0);
        waits = 0;
        while (!tgt_rst && waits < 100) begin
            @(negedge seq);
            waits++;
        end
        if (!tgt_rst) begin
            errors++;
            $display("tgt_rst never rose after the RESET action");
        end
        hold = 0;
        while (tgt_rst && hold < 200) begin
            @(negedge seq);
            hold++;
        end
        if (hold < `SYSCFG_RST_HOLD) report_value("tgt_rst high cycles", `SYSCFG_RST_HOLD, hold);
        status_shadow = 2'b00;
        wait_status();
        if (tgt_rst !== 1'b0) report_value("tgt_rst", 32'd0, 32'(tgt_rst));

        // Random interrupt masks, sparse vectors give a mix of both outcomes
        for (int n = 0; n < 50; n++) begin
            ier_word = take_bits(32);
            apb_write(ADDR_IER, ier_word, 4'hf, 1'b0);
            @(negedge seq);
            irq_vec = take_bits(32) & take_bits(32) & take_bits(32);
            @(negedge seq);
            if (tgt_irq !== irq_expect(ier_shadow, irq_vec)) begin
                report_value("tgt_irq", 32'(irq_expect(ier_shadow, irq_vec)), 32'(tgt_irq));
            end
        end

        repeat (2) @(negedge seq);
        if (exp_q.size() != 0) begin
            errors++;
            $display("Some APB transfers were never compared");
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+logic
logic/syscfg_pkg.sv
logic/syscfg_ctl_if.sv
logic/rst_hold_timer.sv
logic/syscfg_regs.sv
logic/syscfg_maestro.sv
logic/syscfg_tgt.sv
verif/tb_clock.sv
verif/syscfg_tb.sv

//--- Makefile
# Verilator flow for the system configuration target

TOP := syscfg_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module syscfg_tgt -f src.f
	verilator --lint-only --timing --top-module $(TOP) -f src.f

# Exit status comes from the search for the pass line
sim:
	verilator --binary --timing --top-module $(TOP) -Mdir obj_dir -f src.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir
